// File: ebusPkg.sv
`default_nettype none

package ebusPkg;

  // Word fields use KL10 numbering, bit 0 is the most significant
  typedef logic [0:35] ebusWord;
  typedef logic [13:35] vmaAdr;
  typedef logic [0:7] aprFlags;
  // Mask index is the interrupt level, level 1 has the highest priority
  typedef logic [1:7] piMask;

  // Codes and level numbers are plain binary values
  typedef logic [6:0] diagAdr;
  typedef logic [2:0] unitCode;
  typedef logic [3:0] funcCode;
  typedef logic [2:0] piLevelNum;

  // Unit codes in the upper three bits of a diagnostic address
  localparam unitCode unitApr = 3'd1;
  localparam unitCode unitPi = 3'd2;
  localparam unitCode unitVma = 3'd3;

  localparam funcCode aprRead = 4'd0;
  localparam funcCode aprSetFlags = 4'd1;
  localparam funcCode aprClrFlags = 4'd2;

  localparam funcCode piRead = 4'd0;
  localparam funcCode piWrEnable = 4'd1;
  localparam funcCode piSetReq = 4'd2;
  localparam funcCode piClrReq = 4'd3;

  localparam funcCode vmaRead = 4'd0;
  localparam funcCode vmaLoad = 4'd1;
  localparam funcCode vmaIncr = 4'd2;

  // Sticky error flags, bits 3 to 7 are left to software
  localparam int aprSbusErrBit = 0;
  localparam int aprNxmErrBit = 1;
  localparam int aprParErrBit = 2;

  typedef enum logic [1:0] {
    decIdle,
    decExec,
    decDrive,
    decAck
  } decState;

endpackage

`default_nettype wire

// File: ebusDecode.sv
`timescale 1ns/1ps
`default_nettype none

module ebusDecode
  import ebusPkg::*;
(
  input wire clk,
  input wire rstN,
  input wire cyc,
  input wire stb,
  input wire we,
  input wire diagAdr adr,
  input wire ebusWord datIn,
  output logic ack,
  output logic aprSel,
  output logic piSel,
  output logic vmaSel,
  output logic funcStb,
  output ebusPkg::funcCode funcCode,
  output logic funcWrite,
  output ebusWord funcData,
  output logic capture
);

  decState state;
  decState stateNext;
  logic pending;
  logic accept;
  logic active;
  unitCode unitReg;

  // A console cycle is taken only from an idle bus with nothing latched yet
  assign accept = (state == decIdle) && !pending && cyc && stb;

  // The function and its data are held until the ack has gone out
  always_ff @(posedge clk) begin
    if (accept) begin
      unitReg <= adr[6:4];
      funcCode <= adr[3:0];
      funcWrite <= we;
      funcData <= datIn;
    end
  end

  // The pending flag covers the cycle between acceptance and decExec
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= decIdle;
      pending <= 1'b0;
    end else begin
      state <= stateNext;
      pending <= accept;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      decIdle: begin
        if (pending) begin
          stateNext = decExec;
        end
      end
      decExec: stateNext = decDrive;
      decDrive: stateNext = decAck;
      decAck: stateNext = decIdle;
      default: stateNext = decIdle;
    endcase
  end

  assign active = (state != decIdle);

  // Unknown unit codes leave every select low, so nothing acts or drives
  assign aprSel = active && (unitReg == unitApr);
  assign piSel = active && (unitReg == unitPi);
  assign vmaSel = active && (unitReg == unitVma);

  assign funcStb = (state == decExec);
  assign capture = (state == decDrive);
  assign ack = (state == decAck);

endmodule

`default_nettype wire

// File: aprUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aprUnit
  import ebusPkg::*;
(
  input wire clk,
  input wire rstN,
  input wire sel,
  input wire funcStb,
  input wire ebusPkg::funcCode funcCode,
  input wire funcWrite,
  input wire ebusWord funcData,
  input wire sbusErr,
  input wire nxmErr,
  input wire parErr,
  output logic driving,
  output ebusWord data
);

  aprFlags flags;
  aprFlags flagsNext;
  aprFlags dataFlags;

  // Flag bit 0 lines up with word bit 28
  assign dataFlags = funcData[28:35];

  always_comb begin
    flagsNext = flags;
    if (sel && funcStb && funcWrite) begin
      case (funcCode)
        aprSetFlags: flagsNext = flags | dataFlags;
        aprClrFlags: flagsNext = flags & ~dataFlags;
        default: flagsNext = flags;
      endcase
    end
    // Error inputs are applied last so they win over a clear
    if (sbusErr) begin
      flagsNext[aprSbusErrBit] = 1'b1;
    end
    if (nxmErr) begin
      flagsNext[aprNxmErrBit] = 1'b1;
    end
    if (parErr) begin
      flagsNext[aprParErrBit] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      flags <= flagsNext;
    end
  end

  assign driving = sel && !funcWrite && (funcCode == aprRead);
  assign data = {28'b0, flags};

endmodule

`default_nettype wire

// File: piUnit.sv
`timescale 1ns/1ps
`default_nettype none

module piUnit
  import ebusPkg::*;
(
  input wire clk,
  input wire rstN,
  input wire sel,
  input wire funcStb,
  input wire ebusPkg::funcCode funcCode,
  input wire funcWrite,
  input wire ebusWord funcData,
  input wire piMask piReq,
  output logic driving,
  output ebusWord data,
  output piLevelNum piLevel
);

  piMask reqMask;
  piMask reqNext;
  piMask enMask;
  piMask dataMask;
  piMask activeMask;
  logic doWrite;

  // Level 1 sits at word bit 29, level 7 at bit 35
  assign dataMask = funcData[29:35];
  assign doWrite = sel && funcStb && funcWrite;

  always_comb begin
    reqNext = reqMask;
    if (doWrite && (funcCode == piSetReq)) begin
      reqNext = reqMask | dataMask;
    end else if (doWrite && (funcCode == piClrReq)) begin
      reqNext = reqMask & ~dataMask;
    end
    // Hardware requests override a clear in the same cycle
    reqNext = reqNext | piReq;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      reqMask <= '0;
      enMask <= '1;
    end else begin
      reqMask <= reqNext;
      if (doWrite && (funcCode == piWrEnable)) begin
        enMask <= dataMask;
      end
    end
  end

  assign activeMask = reqMask & enMask;

  // Scan from the lowest priority up so the highest active level is left
  always_comb begin
    piLevel = '0;
    for (int k = 7; k >= 1; k--) begin
      if (activeMask[k]) begin
        piLevel = piLevelNum'(k);
      end
    end
  end

  assign driving = sel && !funcWrite && (funcCode == piRead);

  always_comb begin
    data = '0;
    data[19:21] = piLevel;
    data[22:28] = enMask;
    data[29:35] = reqMask;
  end

endmodule

`default_nettype wire

// File: vmaUnit.sv
`timescale 1ns/1ps
`default_nettype none

module vmaUnit
  import ebusPkg::*;
(
  input wire clk,
  input wire rstN,
  input wire sel,
  input wire funcStb,
  input wire ebusPkg::funcCode funcCode,
  input wire funcWrite,
  input wire ebusWord funcData,
  output logic driving,
  output ebusWord data
);

  vmaAdr vma;
  logic doWrite;

  assign doWrite = sel && funcStb && funcWrite;

  // The increment wraps naturally in the 23-bit register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      vma <= '0;
    end else if (doWrite && (funcCode == vmaLoad)) begin
      vma <= funcData[13:35];
    end else if (doWrite && (funcCode == vmaIncr)) begin
      vma <= vma + 23'd1;
    end
  end

  assign driving = sel && !funcWrite && (funcCode == vmaRead);
  assign data = {13'b0, vma};

endmodule

`default_nettype wire

// File: ebusMux.sv
`timescale 1ns/1ps
`default_nettype none

module ebusMux
  import ebusPkg::*;
(
  input wire clk,
  input wire rstN,
  input wire capture,
  input wire aprDriving,
  input wire ebusWord aprData,
  input wire piDriving,
  input wire ebusWord piData,
  input wire vmaDriving,
  input wire ebusWord vmaData,
  output ebusWord datOut
);

  ebusWord ebus;

  // Fixed priority, the first unit that drives owns the bus
  always_comb begin
    if (aprDriving) ebus = aprData;
    else if (piDriving) ebus = piData;
    else if (vmaDriving) ebus = vmaData;
    else ebus = '0;
  end

  // Console read data holds its value between captures
  always_ff @(posedge clk) begin
    if (!rstN) begin
      datOut <= '0;
    end else if (capture) begin
      datOut <= ebus;
    end
  end

endmodule

`default_nettype wire

// File: ebusTop.sv
`timescale 1ns/1ps
`default_nettype none

module ebusTop
  import ebusPkg::*;
(
  input wire clk,
  input wire rstN,
  input wire cyc,
  input wire stb,
  input wire we,
  input wire diagAdr adr,
  input wire ebusWord datIn,
  input wire sbusErr,
  input wire nxmErr,
  input wire parErr,
  input wire piMask piReq,
  output logic ack,
  output ebusWord datOut,
  output piLevelNum piLevel
);

  logic aprSel;
  logic piSel;
  logic vmaSel;
  logic funcStb;
  ebusPkg::funcCode funcCode;
  logic funcWrite;
  ebusWord funcData;
  logic capture;

  // Each unit owns its own driver onto the EBUS
  logic aprDriving;
  ebusWord aprData;
  logic piDriving;
  ebusWord piData;
  logic vmaDriving;
  ebusWord vmaData;

  ebusDecode ebusDecode_inst (
    .clk(clk),
    .rstN(rstN),
    .cyc(cyc),
    .stb(stb),
    .we(we),
    .adr(adr),
    .datIn(datIn),
    .ack(ack),
    .aprSel(aprSel),
    .piSel(piSel),
    .vmaSel(vmaSel),
    .funcStb(funcStb),
    .funcCode(funcCode),
    .funcWrite(funcWrite),
    .funcData(funcData),
    .capture(capture)
  );

  aprUnit aprUnit_inst (
    .clk(clk),
    .rstN(rstN),
    .sel(aprSel),
    .funcStb(funcStb),
    .funcCode(funcCode),
    .funcWrite(funcWrite),
    .funcData(funcData),
    .sbusErr(sbusErr),
    .nxmErr(nxmErr),
    .parErr(parErr),
    .driving(aprDriving),
    .data(aprData)
  );

  piUnit piUnit_inst (
    .clk(clk),
    .rstN(rstN),
    .sel(piSel),
    .funcStb(funcStb),
    .funcCode(funcCode),
    .funcWrite(funcWrite),
    .funcData(funcData),
    .piReq(piReq),
    .driving(piDriving),
    .data(piData),
    .piLevel(piLevel)
  );

  vmaUnit vmaUnit_inst (
    .clk(clk),
    .rstN(rstN),
    .sel(vmaSel),
    .funcStb(funcStb),
    .funcCode(funcCode),
    .funcWrite(funcWrite),
    .funcData(funcData),
    .driving(vmaDriving),
    .data(vmaData)
  );

  ebusMux ebusMux_inst (
    .clk(clk),
    .rstN(rstN),
    .capture(capture),
    .aprDriving(aprDriving),
    .aprData(aprData),
    .piDriving(piDriving),
    .piData(piData),
    .vmaDriving(vmaDriving),
    .vmaData(vmaData),
    .datOut(datOut)
  );

endmodule

`default_nettype wire

// File: tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
  output logic clk
);

  // Free-running 10 ns clock, low for the first half period
  initial begin
    clk = 1'b0;
  end

  always begin
    #5 clk = ~clk;
  end

endmodule

`default_nettype wire

// File: ebusTb.sv
`timescale 1ns/1ps
`default_nettype none

module ebusTb
  import ebusPkg::*;
();

  // Roughly the number of console functions issued by the sequence below
  localparam int plannedFuncs = 140;
  localparam int watchdogNs = (plannedFuncs * 200 + 50) * 10;
  // Ack is seen on the fourth falling edge, three cycles after acceptance
  localparam int ackNegedge = 4;

  logic clk;
  logic rstN;
  logic cyc;
  logic stb;
  logic we;
  diagAdr adr;
  ebusWord datIn;
  logic sbusErr;
  logic nxmErr;
  logic parErr;
  piMask piReq;
  logic ack;
  ebusWord datOut;
  piLevelNum piLevel;

  // Reference model of the unit registers
  aprFlags aprModel;
  piMask reqModel;
  piMask enModel;
  vmaAdr vmaModel;
  logic [15:0] lfsr;

  ebusWord gotWords[$];
  ebusWord expWords[$];
  piLevelNum gotLevels[$];
  piLevelNum expLevels[$];
  int wordErrors = 0;
  int levelErrors = 0;
  int handshakeErrors = 0;

  tbClockGen tbClockGen_inst (.clk(clk));

  ebusTop ebusTop_inst (.*);

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    // Taps 16, 14, 13 and 11
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic ebusWord randBits(input int n);
    ebusWord v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[1:35], lfsr[0]};
    end
    return v;
  endfunction

  function automatic diagAdr makeAdr(input unitCode u, input funcCode f);
    return {u, f};
  endfunction

  // Lowest numbered level that is both requested and enabled
  function automatic piLevelNum expectedLevel();
    piLevelNum lvl;
    lvl = '0;
    for (int k = 1; k <= 7; k++) begin
      if (lvl == '0 && reqModel[k] && enModel[k]) begin
        lvl = piLevelNum'(k);
      end
    end
    return lvl;
  endfunction

  function automatic ebusWord expectedRead(input diagAdr a);
    ebusWord w;
    w = '0;
    if (a == makeAdr(unitApr, aprRead)) begin
      w[28:35] = aprModel;
    end else if (a == makeAdr(unitPi, piRead)) begin
      w[19:21] = expectedLevel();
      w[22:28] = enModel;
      w[29:35] = reqModel;
    end else if (a == makeAdr(unitVma, vmaRead)) begin
      w[13:35] = vmaModel;
    end
    return w;
  endfunction

  task automatic applyModel(input diagAdr a, input ebusWord d);
    if (a == makeAdr(unitApr, aprSetFlags)) begin
      aprModel = aprModel | d[28:35];
    end else if (a == makeAdr(unitApr, aprClrFlags)) begin
      aprModel = aprModel & ~d[28:35];
    end else if (a == makeAdr(unitPi, piWrEnable)) begin
      enModel = d[29:35];
    end else if (a == makeAdr(unitPi, piSetReq)) begin
      reqModel = reqModel | d[29:35];
    end else if (a == makeAdr(unitPi, piClrReq)) begin
      reqModel = reqModel & ~d[29:35];
    end else if (a == makeAdr(unitVma, vmaLoad)) begin
      vmaModel = d[13:35];
    end else if (a == makeAdr(unitVma, vmaIncr)) begin
      vmaModel = vmaModel + 23'd1;
    end
  endtask

  task automatic checkWord(input string name, input ebusWord got, input ebusWord exp);
    if (got !== exp) begin
      wordErrors++;
      $display("FAILED t=%0t %s got %09h expected %09h", $time, name, got, exp);
    end
  endtask

  task automatic checkLevel(input string name, input piLevelNum got, input piLevelNum exp);
    if (got !== exp) begin
      levelErrors++;
      $display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // Runs one Wishbone classic cycle, entered and left on a falling edge
  task automatic runFunction(input diagAdr a, input logic w, input ebusWord d,
                             output ebusWord rd);
    int cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    cyc = 1'b1;
    stb = 1'b1;
    we = w;
    adr = a;
    datIn = d;
    while (!seen && cycles < 10) begin
      @(negedge clk);
      cycles++;
      seen = ack;
    end
    rd = datOut;
    cyc = 1'b0;
    stb = 1'b0;
    if (!seen) begin
      handshakeErrors++;
      $display("Function %h at %0t was never acknowledged", a, $time);
    end else if (cycles != ackNegedge) begin
      handshakeErrors++;
      $display("Function %h at %0t was acknowledged %0d cycles after acceptance, not 3",
               a, $time, cycles - 1);
    end
    @(negedge clk);
    if (ack) begin
      handshakeErrors++;
      $display("Ack for function %h at %0t lasted more than one cycle", a, $time);
    end
  endtask

  task automatic queueLevel();
    gotLevels.push_back(piLevel);
    expLevels.push_back(expectedLevel());
  endtask

  task automatic issueWrite(input diagAdr a, input ebusWord d);
    ebusWord unused;
    runFunction(a, 1'b1, d, unused);
    applyModel(a, d);
    queueLevel();
  endtask

  task automatic issueRead(input diagAdr a);
    ebusWord got;
    ebusWord exp;
    exp = expectedRead(a);
    runFunction(a, 1'b0, '0, got);
    gotWords.push_back(got);
    expWords.push_back(exp);
  endtask

  // Bit 0 is the SBUS error, then NXM, then parity
  task automatic pulseErrors(input logic [0:2] e);
    sbusErr = e[0];
    nxmErr = e[1];
    parErr = e[2];
    @(negedge clk);
    sbusErr = 1'b0;
    nxmErr = 1'b0;
    parErr = 1'b0;
    aprModel[0:2] = aprModel[0:2] | e;
  endtask

  task automatic pulsePiReq(input piMask m);
    piReq = m;
    @(negedge clk);
    piReq = '0;
    reqModel = reqModel | m;
    queueLevel();
  endtask

  always @(posedge clk) begin
    while (gotWords.size() != 0) begin
      checkWord("datOut", gotWords.pop_front(), expWords.pop_front());
    end
    while (gotLevels.size() != 0) begin
      checkLevel("piLevel", gotLevels.pop_front(), expLevels.pop_front());
    end
  end

  initial begin
    #(watchdogNs);
    $display("Watchdog expired after %0d ns before the test sequence finished", watchdogNs);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    ebusWord d;
    ebusWord e;
    rstN = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    datIn = '0;
    sbusErr = 1'b0;
    nxmErr = 1'b0;
    parErr = 1'b0;
    piReq = '0;
    lfsr = 16'd4;
    aprModel = '0;
    reqModel = '0;
    enModel = '1;
    vmaModel = '0;
    repeat (3) @(negedge clk);
    rstN = 1'b1;

    queueLevel();
    issueRead(makeAdr(unitApr, aprRead));
    issueRead(makeAdr(unitPi, piRead));
    issueRead(makeAdr(unitVma, vmaRead));

    for (int i = 0; i < 20; i++) begin
      e = randBits(1);
      d = randBits(36);
      if (e[35]) begin
        issueWrite(makeAdr(unitApr, aprSetFlags), d);
      end else begin
        issueWrite(makeAdr(unitApr, aprClrFlags), d);
      end
      if (i % 4 == 3) begin
        e = randBits(3);
        pulseErrors(e[33:35]);
      end
      issueRead(makeAdr(unitApr, aprRead));
    end
    // Clearing only the software flags must leave the sticky errors set
    pulseErrors(3'b111);
    issueWrite(makeAdr(unitApr, aprClrFlags), 36'h1f);
    issueRead(makeAdr(unitApr, aprRead));
    issueWrite(makeAdr(unitApr, aprClrFlags), 36'hff);
    issueRead(makeAdr(unitApr, aprRead));

    for (int i = 0; i < 20; i++) begin
      e = randBits(2);
      d = randBits(36);
      case (e[34:35])
        2'd0: issueWrite(makeAdr(unitPi, piWrEnable), d);
        2'd1: issueWrite(makeAdr(unitPi, piSetReq), d);
        2'd2: issueWrite(makeAdr(unitPi, piClrReq), d);
        default: pulsePiReq(d[29:35]);
      endcase
      issueRead(makeAdr(unitPi, piRead));
    end

    for (int i = 0; i < 8; i++) begin
      issueWrite(makeAdr(unitVma, vmaLoad), randBits(36));
      issueRead(makeAdr(unitVma, vmaRead));
    end
    for (int i = 0; i < 4; i++) begin
      issueWrite(makeAdr(unitVma, vmaIncr), '0);
      issueRead(makeAdr(unitVma, vmaRead));
    end
    // All ones wraps to zero
    issueWrite(makeAdr(unitVma, vmaLoad), '1);
    issueWrite(makeAdr(unitVma, vmaIncr), '0);
    issueRead(makeAdr(unitVma, vmaRead));

    for (int u = 0; u < 8; u++) begin
      if (u >= 1 && u <= 3) begin
        continue;
      end
      d = randBits(36);
      e = randBits(4);
      issueWrite(makeAdr(unitCode'(u), e[32:35]), d);
      issueRead(makeAdr(unitCode'(u), 4'd0));
    end
    issueWrite(makeAdr(unitApr, 4'd7), '1);
    issueWrite(makeAdr(unitPi, 4'd9), '1);
    issueWrite(makeAdr(unitVma, 4'd12), '1);
    issueRead(makeAdr(unitApr, aprSetFlags));
    issueRead(makeAdr(unitPi, piClrReq));
    issueRead(makeAdr(unitVma, vmaIncr));
    issueRead(makeAdr(unitApr, aprRead));
    issueRead(makeAdr(unitPi, piRead));
    issueRead(makeAdr(unitVma, vmaRead));

    repeat (2) @(negedge clk);
    $display("Errors: %0d datOut, %0d piLevel, %0d handshake",
             wordErrors, levelErrors, handshakeErrors);
    if (wordErrors + levelErrors + handshakeErrors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ebusTop.f
ebusPkg.sv
ebusDecode.sv
aprUnit.sv
piUnit.sv
vmaUnit.sv
ebusMux.sv
ebusTop.sv
tbClockGen.sv
ebusTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the EBUS testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module ebusTb -f ebusTop.f -o ebusSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ebusSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
exit 1
